//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vtb_mem_arb: tb.f $(wildcard *.sv) tb_mem_arb_util.svh
	verilator --binary --timing --top-module tb_mem_arb -f tb.f -o Vtb_mem_arb

run: obj_dir/Vtb_mem_arb
	./obj_dir/Vtb_mem_arb > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q "Simulation failed" sim.log

lint:
	verilator --lint-only --timing --top-module tb_mem_arb -f tb.f

clean:
	rm -rf obj_dir sim.log

//--- mem_arb_pkg.sv
package mem_arb_pkg;

   // Memory geometry
   parameter int ADDR_W = 10;             // Word address bits
   parameter int DATA_W = 32;             // Data word bits

   // Requesting masters, port 0 is the system and port 1 the tester
   parameter int NUM_PORTS = 2;

   // Internal reset outlasts the board reset by this many cycles
   parameter int RST_STRETCH = 10;

   // Word address into the shared memory
   typedef logic [ADDR_W-1:0] addr_t;

   // One data word
   typedef logic [DATA_W-1:0] data_t;

   // Index of the port a request came from
   typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

   // Reset sequencer states
   typedef enum logic [1:0] {
      HOLD    = 2'd0,                     // Board reset asserted
      STRETCH = 2'd1,                     // Counting out the extra cycles
      RUN     = 2'd2                      // Normal operation
   } rst_state_t;

endpackage

//--- mem_arb_top.sv
`timescale 1ns/1ps

module mem_arb_top import mem_arb_pkg::*; #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic  clk,
   input  logic  reset,
   input  logic  req_valid_0,
   input  logic  req_write_0,
   input  addr_t req_addr_0,
   input  data_t req_wdata_0,
   input  logic  req_valid_1,
   input  logic  req_write_1,
   input  addr_t req_addr_1,
   input  data_t req_wdata_1,
   output logic  ready,
   output logic  credit_return_0,
   output logic  credit_return_1,
   output logic  rsp_valid_0,
   output logic  rsp_valid_1,
   output data_t rsp_rdata_0,
   output data_t rsp_rdata_1
);

   logic  rst_int;
   logic  not_empty_0;
   logic  not_empty_1;
   logic  head_write_0;
   logic  head_write_1;
   addr_t head_addr_0;
   addr_t head_addr_1;
   data_t head_wdata_0;
   data_t head_wdata_1;
   logic  pop_0;
   logic  pop_1;

   mem_req_if req_bus ();                 // Arbiter to memory
   mem_rsp_if rsp_bus ();                 // Memory to router

   reset_seq u_reset_seq (
      .clk     (clk),
      .reset   (reset),
      .rst_int (rst_int),
      .ready   (ready)
   );

   // Port 0, system side
   port_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue_0 (
      .clk           (clk),
      .rst_int       (rst_int),
      .push          (req_valid_0),
      .push_write    (req_write_0),
      .push_addr     (req_addr_0),
      .push_wdata    (req_wdata_0),
      .pop           (pop_0),
      .not_empty     (not_empty_0),
      .head_write    (head_write_0),
      .head_addr     (head_addr_0),
      .head_wdata    (head_wdata_0),
      .credit_return (credit_return_0)
   );

   // Port 1, tester side
   port_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue_1 (
      .clk           (clk),
      .rst_int       (rst_int),
      .push          (req_valid_1),
      .push_write    (req_write_1),
      .push_addr     (req_addr_1),
      .push_wdata    (req_wdata_1),
      .pop           (pop_1),
      .not_empty     (not_empty_1),
      .head_write    (head_write_1),
      .head_addr     (head_addr_1),
      .head_wdata    (head_wdata_1),
      .credit_return (credit_return_1)
   );

   req_arbiter u_arbiter (
      .clk          (clk),
      .rst_int      (rst_int),
      .not_empty_0  (not_empty_0),
      .not_empty_1  (not_empty_1),
      .head_write_0 (head_write_0),
      .head_addr_0  (head_addr_0),
      .head_wdata_0 (head_wdata_0),
      .head_write_1 (head_write_1),
      .head_addr_1  (head_addr_1),
      .head_wdata_1 (head_wdata_1),
      .pop_0        (pop_0),
      .pop_1        (pop_1),
      .req          (req_bus.src)
   );

   mem_stage u_mem (
      .clk     (clk),
      .rst_int (rst_int),
      .req     (req_bus.dst),
      .rsp     (rsp_bus.src)
   );

   rsp_router u_router (
      .clk         (clk),
      .rst_int     (rst_int),
      .rsp         (rsp_bus.dst),
      .rsp_valid_0 (rsp_valid_0),
      .rsp_valid_1 (rsp_valid_1),
      .rsp_rdata_0 (rsp_rdata_0),
      .rsp_rdata_1 (rsp_rdata_1)
   );

endmodule

//--- mem_if.sv
`timescale 1ns/1ps

// Single word request headed for the memory, tagged with its port
interface mem_req_if import mem_arb_pkg::*; ();

   logic  valid;
   logic  write;                          // 1 for write, 0 for read
   addr_t addr;
   data_t wdata;
   port_t port;                           // Port that issued the request

   modport src (output valid, output write, output addr, output wdata, output port);
   modport dst (input valid, input write, input addr, input wdata, input port);

endinterface

// One response per request, no back-pressure
interface mem_rsp_if import mem_arb_pkg::*; ();

   logic  valid;
   logic  write;                          // Acknowledge of a write
   data_t rdata;                          // Zero for write acknowledgements
   port_t port;

   modport src (output valid, output write, output rdata, output port);
   modport dst (input valid, input write, input rdata, input port);

endinterface

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage import mem_arb_pkg::*; (
   input  logic   clk,
   input  logic   rst_int,
   mem_req_if.dst req,
   mem_rsp_if.src rsp
);

   localparam int MEM_WORDS = 2 ** ADDR_W;

   data_t mem [MEM_WORDS];

   // Power-up contents, unwritten words read as zero
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (req.valid && req.write) begin
         mem[req.addr] <= req.wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_int) begin
         rsp.valid <= 1'b0;
      end else begin
         rsp.valid <= req.valid;          // Every request gets one response
      end
   end

   // Response payload follows the request by one cycle
   always_ff @(posedge clk) begin
      rsp.write <= req.write;
      rsp.port  <= req.port;
      if (req.write) begin
         rsp.rdata <= '0;                 // Plain acknowledge
      end else begin
         rsp.rdata <= mem[req.addr];
      end
   end

   // Address arriving from the arbiter must be resolved
   a_addr_known: assert property (@(posedge clk) disable iff (rst_int)
      req.valid |-> !$isunknown({req.write, req.addr}));

endmodule

//--- port_queue.sv
`timescale 1ns/1ps

module port_queue import mem_arb_pkg::*; #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic  clk,
   input  logic  rst_int,
   input  logic  push,
   input  logic  push_write,
   input  addr_t push_addr,
   input  data_t push_wdata,
   input  logic  pop,
   output logic  not_empty,
   output logic  head_write,
   output addr_t head_addr,
   output data_t head_wdata,
   output logic  credit_return
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);

   logic             write_q [QUEUE_DEPTH];
   addr_t            addr_q  [QUEUE_DEPTH];
   data_t            wdata_q [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;               // One extra bit to hold a full count

   // Entry storage
   always_ff @(posedge clk) begin
      if (push) begin
         write_q[wr_ptr] <= push_write;
         addr_q[wr_ptr]  <= push_addr;
         wdata_q[wr_ptr] <= push_wdata;
      end
   end

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (rst_int) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // Idle, or push and pop together
         endcase
      end
   end

   assign not_empty  = (count != '0);
   assign head_write = write_q[rd_ptr];
   assign head_addr  = addr_q[rd_ptr];
   assign head_wdata = wdata_q[rd_ptr];

   // Freed slot goes back to the master as a credit
   assign credit_return = pop;

   // A master that respects its credits never overfills the queue
   a_no_overflow: assert property (@(posedge clk) disable iff (rst_int)
      push |-> (count < (PTR_W + 1)'(QUEUE_DEPTH)) || pop);

   // Arbiter only pops a queue it saw holding an entry
   a_no_underflow: assert property (@(posedge clk) disable iff (rst_int)
      pop |-> not_empty);

endmodule

//--- req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter import mem_arb_pkg::*; (
   input  logic  clk,
   input  logic  rst_int,
   input  logic  not_empty_0,
   input  logic  not_empty_1,
   input  logic  head_write_0,
   input  addr_t head_addr_0,
   input  data_t head_wdata_0,
   input  logic  head_write_1,
   input  addr_t head_addr_1,
   input  data_t head_wdata_1,
   output logic  pop_0,
   output logic  pop_1,
   mem_req_if.src req
);

   port_t last_grant;                     // Winner of the previous grant
   port_t grant;
   logic  grant_valid;

   // Round robin between the two queues
   always_comb begin
      grant_valid = not_empty_0 | not_empty_1;
      if (not_empty_0 && not_empty_1) begin
         grant = ~last_grant;             // Take turns while both wait
      end else if (not_empty_1) begin
         grant = port_t'(1);
      end else begin
         grant = port_t'(0);
      end
   end

   assign pop_0 = grant_valid && (grant == port_t'(0));
   assign pop_1 = grant_valid && (grant == port_t'(1));

   always_ff @(posedge clk) begin
      if (rst_int) begin
         req.valid  <= 1'b0;
         last_grant <= port_t'(1);        // So port 0 wins the first tie
      end else begin
         req.valid <= grant_valid;
         if (grant_valid) begin
            last_grant <= grant;
         end
      end
   end

   // Chosen head tagged with its port
   always_ff @(posedge clk) begin
      req.port <= grant;
      if (grant == port_t'(1)) begin
         req.write <= head_write_1;
         req.addr  <= head_addr_1;
         req.wdata <= head_wdata_1;
      end else begin
         req.write <= head_write_0;
         req.addr  <= head_addr_0;
         req.wdata <= head_wdata_0;
      end
   end

   // A waiting queue that loses one grant wins the next
   a_no_starve_0: assert property (@(posedge clk) disable iff (rst_int)
      not_empty_0 && !pop_0 |=> pop_0);

   a_no_starve_1: assert property (@(posedge clk) disable iff (rst_int)
      not_empty_1 && !pop_1 |=> pop_1);

endmodule

//--- reset_seq.sv
`timescale 1ns/1ps

module reset_seq import mem_arb_pkg::*; (
   input  logic clk,
   input  logic reset,
   output logic rst_int,
   output logic ready
);

   localparam int CNT_W = $clog2(RST_STRETCH + 1);

   rst_state_t       state;
   rst_state_t       state_nxt;
   logic [CNT_W-1:0] cnt;                 // Cycles spent in STRETCH

   always_comb begin
      case (state)
         HOLD:    state_nxt = STRETCH;    // Board reset has just dropped
         STRETCH: state_nxt = (cnt == CNT_W'(RST_STRETCH - 1)) ? RUN : STRETCH;
         RUN:     state_nxt = RUN;
         default: state_nxt = HOLD;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= HOLD;
         cnt     <= '0;
         rst_int <= 1'b1;
         ready   <= 1'b0;
      end else begin
         state   <= state_nxt;
         rst_int <= (state_nxt != RUN);
         ready   <= (state_nxt == RUN);
         if (state == STRETCH) begin
            cnt <= cnt + 1'b1;
         end else begin
            cnt <= '0;
         end
      end
   end

endmodule

//--- rsp_router.sv
`timescale 1ns/1ps

module rsp_router import mem_arb_pkg::*; (
   input  logic   clk,
   input  logic   rst_int,
   mem_rsp_if.dst rsp,
   output logic   rsp_valid_0,
   output logic   rsp_valid_1,
   output data_t  rsp_rdata_0,
   output data_t  rsp_rdata_1
);

   // Steer by the port tag
   always_ff @(posedge clk) begin
      if (rst_int) begin
         rsp_valid_0 <= 1'b0;
         rsp_valid_1 <= 1'b0;
      end else begin
         rsp_valid_0 <= rsp.valid && (rsp.port == port_t'(0));
         rsp_valid_1 <= rsp.valid && (rsp.port == port_t'(1));
      end
   end

   // Data register of the addressed port
   always_ff @(posedge clk) begin
      if (rsp.port == port_t'(0)) begin
         rsp_rdata_0 <= rsp.rdata;
      end
      if (rsp.port == port_t'(1)) begin
         rsp_rdata_1 <= rsp.rdata;
      end
   end

   // Write acknowledgements arrive with zero data
   a_ack_zero: assert property (@(posedge clk) disable iff (rst_int)
      rsp.valid && rsp.write |-> rsp.rdata == '0);

endmodule

//--- tb.f
+incdir+.
mem_arb_pkg.sv
mem_if.sv
port_queue.sv
req_arbiter.sv
mem_stage.sv
rsp_router.sv
reset_seq.sv
mem_arb_top.sv
tb_mem_arb.sv

//--- tb_mem_arb_util.svh
`ifndef TB_MEM_ARB_UTIL_SVH
`define TB_MEM_ARB_UTIL_SVH

// Shadow copy of the shared memory, kept in issue order
data_t       shadow  [2**ADDR_W];
bit          written [2**ADDR_W];          // Words that hold a known value
logic [15:0] lfsr_state = 16'd36;

// Expected response data for one request
function automatic data_t ref_access(input logic wr, input addr_t addr, input data_t wdata);
   data_t result;
   if (wr) begin
      shadow[addr]  = wdata;
      written[addr] = 1'b1;
      result        = '0;                  // Write acknowledge carries zero
   end else begin
      result = shadow[addr];
   end
   return result;
endfunction

// 16 bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] value;
   logic        fb;
   int          i;
   value = '0;
   for (i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      value      = {value[30:0], fb};
   end
   return value;
endfunction

// Until every request has its response and every credit is back
task automatic wait_drained(input int limit);
   int n;
   n = 0;
   while (!(rcv_0 == exp_q0.size() && rcv_1 == exp_q1.size() &&
            returned_0 == issued_0 && returned_1 == issued_1) && n < limit) begin
      next_cycle();
      n++;
   end
   if (n >= limit) begin
      $display("ERROR at %0t: outstanding requests never completed", $time);
      drv_errors++;
   end
endtask

`endif

//--- tb_mem_arb.sv
`timescale 1ns/1ps

module tb_mem_arb import mem_arb_pkg::*; ();

   localparam int QUEUE_DEPTH = 4;
   localparam int LIMIT       = 2000;      // Cycles allowed for any one wait
   localparam int M_WRITE     = 0;
   localparam int M_READBACK  = 1;
   localparam int M_SHARED    = 2;
   localparam int M_MIXED     = 3;
   localparam int SHARED_N    = 16;
   localparam addr_t SHARED_BASE = 10'h100; // Written by port 0 and read by port 1

   logic  clk = 1'b0;
   logic  reset;
   logic  req_valid_0, req_write_0, req_valid_1, req_write_1;
   addr_t req_addr_0, req_addr_1;
   data_t req_wdata_0, req_wdata_1;
   logic  ready, credit_return_0, credit_return_1, rsp_valid_0, rsp_valid_1;
   data_t rsp_rdata_0, rsp_rdata_1;

   data_t exp_q0[$];
   data_t exp_q1[$];
   addr_t rb_q[$];                          // Addresses to read back
   int    issued_0 = 0, issued_1 = 0, returned_0 = 0, returned_1 = 0;
   int    rcv_0 = 0, rcv_1 = 0, fair_base_0 = 0, fair_base_1 = 0;
   int    drv_errors = 0, mon_errors = 0, mismatches = 0, cyc = 0, diff;
   bit    fair_on = 1'b0;

   `include "tb_mem_arb_util.svh"

   always #4 clk = ~clk;

   mem_arb_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (.*);

   task automatic next_cycle();
      @(negedge clk);
      req_valid_0 = 1'b0;
      req_valid_1 = 1'b0;
   endtask

   task automatic issue(input int port, input logic wr, input addr_t addr, input data_t d);
      data_t exp;
      exp = ref_access(wr, addr, d);       // Port 0 first within a cycle
      if (port == 0) begin
         {req_valid_0, req_write_0, req_addr_0, req_wdata_0} = {1'b1, wr, addr, d};
         exp_q0.push_back(exp);
         issued_0++;
      end else begin
         {req_valid_1, req_write_1, req_addr_1, req_wdata_1} = {1'b1, wr, addr, d};
         exp_q1.push_back(exp);
         issued_1++;
      end
   endtask

   task automatic make_req(input int port, input int mode, input int idx,
                           output logic wr, output addr_t addr, output data_t d);
      d  = rand_bits(DATA_W);
      wr = 1'b1;
      case (mode)
         M_WRITE: begin
            addr = addr_t'(rand_bits(8));
            rb_q.push_back(addr);
         end
         M_READBACK: begin
            wr   = 1'b0;
            addr = rb_q[idx];
         end
         M_SHARED: addr = SHARED_BASE + addr_t'(idx);
         default: begin
            wr = 1'(rand_bits(1));
            if (port == 0) begin
               addr = addr_t'(rand_bits(8));          // Lower window below the shared region
            end else if (rand_bits(2) == 0) begin
               wr   = 1'b0;
               addr = SHARED_BASE + addr_t'(rand_bits(4));
            end else begin
               addr = addr_t'(32'h200 | rand_bits(9)); // Upper half
            end
            if (!wr && !written[addr]) wr = 1'b1;     // Never read unknown words
         end
      endcase
   endtask

   // Issue while credits last and skip a port without any
   task automatic run_traffic(input int mode, input int n0, input int n1);
      int    sent0, sent1, guard;
      logic  wr;
      addr_t addr;
      data_t d;
      sent0 = 0;
      sent1 = 0;
      guard = 0;
      while ((sent0 < n0 || sent1 < n1) && guard < LIMIT) begin
         next_cycle();
         if (sent0 < n0 && issued_0 - returned_0 < QUEUE_DEPTH) begin
            make_req(0, mode, sent0, wr, addr, d);
            issue(0, wr, addr, d);
            sent0++;
         end
         if (sent1 < n1 && issued_1 - returned_1 < QUEUE_DEPTH) begin
            make_req(1, mode, sent1, wr, addr, d);
            issue(1, wr, addr, d);
            sent1++;
         end
         guard++;
      end
      next_cycle();
      if (guard >= LIMIT) begin
         $display("ERROR at %0t: no credits came back, traffic stalled", $time);
         drv_errors++;
      end
   endtask

   task automatic compare_rsp(input int port, input data_t got);
      data_t exp;
      int    idx;
      idx = (port == 0) ? rcv_0 : rcv_1;
      if (idx >= ((port == 0) ? exp_q0.size() : exp_q1.size())) begin
         $display("ERROR at %0t: port %0d got a response it never asked for", $time, port);
         mon_errors++;
      end else begin
         exp = (port == 0) ? exp_q0[idx] : exp_q1[idx];
         if (got !== exp) begin
            $display("MISMATCH at %0t: port %0d response %0d got %h expected %h",
                     $time, port, idx, got, exp);
            mismatches++;
         end
      end
      if (port == 0) rcv_0++;
      else rcv_1++;
   endtask

   // Compare process on values settled in the previous cycle
   always @(posedge clk) begin
      if (cyc > 0 && ready !== 1'b1) begin
         if ({credit_return_0, credit_return_1, rsp_valid_0, rsp_valid_1} !== 4'b0) begin
            $display("ERROR at %0t: credit or response activity before ready", $time);
            mon_errors++;
         end
      end
      if (credit_return_0 === 1'b1) returned_0++;
      if (credit_return_1 === 1'b1) returned_1++;
      if (returned_0 > issued_0 || returned_1 > issued_1) begin
         $display("ERROR at %0t: credit returned for a request never issued", $time);
         mon_errors++;
      end
      if (rsp_valid_0 === 1'b1) compare_rsp(0, rsp_rdata_0);
      if (rsp_valid_1 === 1'b1) compare_rsp(1, rsp_rdata_1);
      diff = (rcv_0 - fair_base_0) - (rcv_1 - fair_base_1);
      if (fair_on && (diff > QUEUE_DEPTH + 1 || diff < -(QUEUE_DEPTH + 1))) begin
         $display("ERROR at %0t: one port is starving the other", $time);
         mon_errors++;
      end
      cyc++;
   end

   initial begin
      int i, n;
      reset = 1'b1;
      {req_valid_0, req_write_0, req_addr_0, req_wdata_0} = '0;
      {req_valid_1, req_write_1, req_addr_1, req_wdata_1} = '0;
      for (i = 0; i < 10; i++) begin
         @(negedge clk);
         if (ready !== 1'b0) begin
            $display("ERROR at %0t: ready high while board reset is asserted", $time);
            drv_errors++;
         end
      end
      reset = 1'b0;
      for (i = 0; i < RST_STRETCH; i++) begin
         @(negedge clk);
         if (ready !== 1'b0) begin
            $display("ERROR at %0t: ready rose inside the reset stretch", $time);
            drv_errors++;
         end
      end
      n = 0;
      while (ready !== 1'b1 && n < LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (ready !== 1'b1) begin
         $display("ERROR: ready never rose after reset");
         drv_errors++;
      end
      run_traffic(M_WRITE, 24, 0);
      wait_drained(LIMIT);
      run_traffic(M_READBACK, 24, 0);
      wait_drained(LIMIT);
      run_traffic(M_SHARED, SHARED_N, 0);
      wait_drained(LIMIT);                   // Port 0 acks before port 1 reads
      run_traffic(M_MIXED, 60, 60);
      wait_drained(LIMIT);
      fair_base_0 = rcv_0;
      fair_base_1 = rcv_1;
      fair_on = 1'b1;
      run_traffic(M_MIXED, 100, 100);        // Both queues kept full
      fair_on = 1'b0;
      wait_drained(LIMIT);
      repeat (5) next_cycle();               // Quiet tail for stray responses
      if (rcv_0 != issued_0 || rcv_1 != issued_1) begin
         $display("ERROR: response count differs from request count");
         drv_errors++;
      end
      $display("Errors: %0d mismatches, %0d other", mismatches, drv_errors + mon_errors);
      if (mismatches == 0 && drv_errors == 0 && mon_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
